// File: fm_params.svh
`ifndef FM_PARAMS_SVH
`define FM_PARAMS_SVH

// Stream widths on the sys_clk side and the calc_clk side.
`define FM_BEAT_W          256
`define FM_WORD_W          288
`define FM_HALF_W          144

// One group of nine input beats repacks into eight words.
`define FM_BEATS_PER_GROUP 9
`define FM_WORDS_PER_GROUP 8

// Window arithmetic.
`define FM_PIXEL_W         16
`define FM_TAPS            9
`define FM_ACC_W           36

`define FM_BEAT_CNT_W      4
`define FM_TAP_ADDR_W      4

`endif

// File: logic/fm_pkg.sv
`include "fm_params.svh"

package fm_pkg;

    // Stream payloads.
    typedef logic [`FM_BEAT_W-1:0] fm_beat_t;
    typedef logic [`FM_WORD_W-1:0] fm_word_t;
    typedef logic [`FM_HALF_W-1:0] fm_half_t;  // One 3x3 window of pixels.

    // Window arithmetic, all two's complement.
    typedef logic signed [`FM_PIXEL_W-1:0] fm_pixel_t;
    typedef logic signed [`FM_PIXEL_W-1:0] fm_weight_t;
    typedef logic signed [`FM_ACC_W-1:0]   fm_acc_t;

    // Counters and addresses.
    typedef logic [`FM_BEAT_CNT_W-1:0] fm_beat_cnt_t;
    typedef logic [`FM_TAP_ADDR_W-1:0] fm_tap_addr_t;

endpackage

// File: logic/fm_width_converter.sv
`timescale 1ns/1ps
`include "fm_params.svh"

module fm_width_converter
    import fm_pkg::*;
(
    input  logic     sys_clk,
    input  logic     calc_clk,
    input  logic     rstn,
    input  fm_beat_t beat,
    input  logic     beat_valid,
    output fm_half_t half,
    output logic     half_valid
);

    // Each word takes 32 more bits from the new beat than the word before it.
    localparam int SLICE_W = `FM_WORD_W - `FM_BEAT_W;
    localparam int JOIN_W  = `FM_WORD_W + `FM_BEAT_W;
    localparam int SHIFT_W = $clog2(JOIN_W);

    localparam fm_beat_cnt_t LAST_BEAT = fm_beat_cnt_t'(`FM_BEATS_PER_GROUP - 1);

    fm_beat_cnt_t       beat_cnt;      // Beats already taken in this group.
    fm_word_t           hist_buf;
    fm_word_t           word_reg;
    fm_word_t           word_next;
    logic               word_pending;  // A fresh word was registered on the last sys_clk edge.
    logic               phase;         // High while the lower half is due.
    logic [SHIFT_W-1:0] shift_amt;
    logic [JOIN_W-1:0]  joined;

    // The leftover bits of the previous beat sit directly above the new beat,
    // so the word is a window into the joined vector whose offset moves down
    // by one slice per beat.
    always_comb begin
        shift_amt = SHIFT_W'((`FM_WORDS_PER_GROUP - int'(beat_cnt)) * SLICE_W);
        joined    = {hist_buf, beat} >> shift_amt;
        word_next = joined[`FM_WORD_W-1:0];
    end

    always_ff @(posedge sys_clk or negedge rstn) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else if (beat_valid) begin
            if (beat_cnt == LAST_BEAT) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clk or negedge rstn) begin
        if (!rstn) begin
            hist_buf <= '0;
        end else if (beat_valid) begin
            hist_buf <= {hist_buf[SLICE_W-1:0], beat};
        end
    end

    // The first beat of a group only fills the history buffer.
    always_ff @(posedge sys_clk or negedge rstn) begin
        if (!rstn) begin
            word_reg <= '0;
        end else if (beat_valid && (beat_cnt != '0)) begin
            word_reg <= word_next;
        end
    end

    always_ff @(posedge sys_clk or negedge rstn) begin
        if (!rstn) begin
            word_pending <= 1'b0;
        end else begin
            word_pending <= beat_valid && (beat_cnt != '0);
        end
    end

    // A pending word is first seen on the calc_clk edge in the middle of the
    // sys_clk cycle. The lower half then lands on the next sys_clk edge, which
    // still reads the old word_reg, so a word arriving on that edge is safe.
    always_ff @(posedge calc_clk or negedge rstn) begin
        if (!rstn) begin
            phase      <= 1'b0;
            half_valid <= 1'b0;
        end else if (phase) begin
            phase      <= 1'b0;
            half_valid <= 1'b1;
        end else if (word_pending) begin
            phase      <= 1'b1;
            half_valid <= 1'b1;
        end else begin
            half_valid <= 1'b0;
        end
    end

    always_ff @(posedge calc_clk) begin
        if (phase) begin
            half <= word_reg[`FM_HALF_W-1:0];
        end else begin
            half <= word_reg[`FM_WORD_W-1:`FM_HALF_W];  // Upper half goes first.
        end
    end

endmodule

// File: logic/fm_window_mac.sv
`timescale 1ns/1ps
`include "fm_params.svh"

module fm_window_mac
    import fm_pkg::*;
(
    input  logic         sys_clk,
    input  logic         calc_clk,
    input  logic         rstn,
    input  logic         weight_we,
    input  fm_tap_addr_t weight_addr,
    input  fm_weight_t   weight_data,
    input  fm_half_t     window,
    input  logic         window_valid,
    output fm_acc_t      result,
    output logic         result_valid
);

    localparam int PROD_W = 2 * `FM_PIXEL_W;

    localparam fm_tap_addr_t TAP_LIMIT = fm_tap_addr_t'(`FM_TAPS);

    fm_weight_t               weights [`FM_TAPS];
    fm_pixel_t                pixels [`FM_TAPS];
    logic signed [PROD_W-1:0] products [`FM_TAPS];
    logic                     prod_valid;
    fm_acc_t                  prod_sum;

    // Weights are loaded from the sys_clk side and only change while the
    // pipeline is empty, so calc_clk may read them directly.
    always_ff @(posedge sys_clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `FM_TAPS; i++) begin
                weights[i] <= '0;
            end
        end else if (weight_we && (weight_addr < TAP_LIMIT)) begin
            weights[weight_addr] <= weight_data;
        end
    end

    // Pixel 0 is the most significant field of the window.
    always_comb begin
        for (int i = 0; i < `FM_TAPS; i++) begin
            pixels[i] = window[`FM_HALF_W-1-i*`FM_PIXEL_W -: `FM_PIXEL_W];
        end
    end

    // Stage one.
    always_ff @(posedge calc_clk) begin
        for (int i = 0; i < `FM_TAPS; i++) begin
            products[i] <= pixels[i] * weights[i];
        end
    end

    // Nine 32-bit products need four guard bits, which fm_acc_t provides.
    always_comb begin
        prod_sum = '0;
        for (int i = 0; i < `FM_TAPS; i++) begin
            prod_sum = prod_sum + fm_acc_t'(products[i]);
        end
    end

    // Stage two.
    always_ff @(posedge calc_clk) begin
        result <= prod_sum;
    end

    always_ff @(posedge calc_clk or negedge rstn) begin
        if (!rstn) begin
            prod_valid   <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            prod_valid   <= window_valid;
            result_valid <= prod_valid;
        end
    end

endmodule

// File: logic/fm_in_path.sv
`timescale 1ns/1ps

module fm_in_path
    import fm_pkg::*;
(
    input  logic         sys_clk,
    input  logic         calc_clk,
    input  logic         rstn,
    // Feature-map stream.
    input  fm_beat_t     beat,
    input  logic         beat_valid,
    // Weight load port.
    input  logic         weight_we,
    input  fm_tap_addr_t weight_addr,
    input  fm_weight_t   weight_data,
    // One result per window.
    output fm_acc_t      result,
    output logic         result_valid
);

    fm_half_t half;        // Current 3x3 window on calc_clk.
    logic     half_valid;

    fm_width_converter u_width_converter (
        .sys_clk    (sys_clk),
        .calc_clk   (calc_clk),
        .rstn       (rstn),
        .beat       (beat),
        .beat_valid (beat_valid),
        .half       (half),
        .half_valid (half_valid)
    );

    fm_window_mac u_window_mac (
        .sys_clk      (sys_clk),
        .calc_clk     (calc_clk),
        .rstn         (rstn),
        .weight_we    (weight_we),
        .weight_addr  (weight_addr),
        .weight_data  (weight_data),
        .window       (half),
        .window_valid (half_valid),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    input  logic reset_req,
    output logic sys_clk,
    output logic calc_clk,
    output logic rstn
);

    logic por_n;

    assign rstn = por_n && !reset_req;

    // Both clocks come from one process so their rising edges share a time step.
    initial begin
        sys_clk  = 1'b0;
        calc_clk = 1'b0;
        forever begin
            #1 calc_clk = 1'b1;
            sys_clk = 1'b1;
            #1 calc_clk = 1'b0;
            #1 calc_clk = 1'b1;
            sys_clk = 1'b0;
            #1 calc_clk = 1'b0;
        end
    end

    initial begin
        por_n = 1'b0;
        repeat (8) @(posedge sys_clk);
        #0.5 por_n = 1'b1;  // Power-on reset spans eight sys_clk cycles.
    end

endmodule

// File: verif/fm_in_path_assert.sv
`timescale 1ns/1ps

module fm_in_path_assert
    import fm_pkg::*;
(
    input logic    calc_clk,
    input logic    rstn,
    input logic    half_valid,
    input logic    result_valid,
    input fm_acc_t result
);

    logic half_odd;  // An odd number of halves has gone by.

    always_ff @(posedge calc_clk or negedge rstn) begin
        if (!rstn) begin
            half_odd <= 1'b0;
        end else if (half_valid) begin
            half_odd <= !half_odd;
        end
    end

    // A gap in half_valid must never split the upper half from its lower half.
    pair_check: assert property (@(posedge calc_clk) disable iff (!rstn)
        !half_valid |-> !half_odd)
        else $error("half_valid pulse without its partner half");

    latency_check: assert property (@(posedge calc_clk) disable iff (!rstn)
        result_valid == $past(half_valid, 2))
        else $error("result_valid is not half_valid delayed by two calc_clk cycles");

    known_check: assert property (@(posedge calc_clk) disable iff (!rstn)
        result_valid |-> !$isunknown(result))
        else $error("result is unknown while result_valid is high");

    reset_check: assert property (@(posedge calc_clk)
        !rstn |-> !half_valid && !result_valid)
        else $error("valid output high during reset");

endmodule

bind fm_in_path fm_in_path_assert u_fm_in_path_assert (
    .calc_clk     (calc_clk),
    .rstn         (rstn),
    .half_valid   (half_valid),
    .result_valid (result_valid),
    .result       (result)
);

// File: verif/tb_fm_in_path.sv
`timescale 1ns/1ps
`include "fm_params.svh"

module tb_fm_in_path
    import fm_pkg::*;
();

    localparam int GROUP_W     = `FM_BEAT_W * `FM_BEATS_PER_GROUP;
    localparam int DRAIN_LIMIT = 400;

    logic               sys_clk;
    logic               calc_clk;
    logic               rstn;
    logic               reset_req;
    fm_beat_t           beat;
    logic               beat_valid;
    logic               weight_we;
    fm_tap_addr_t       weight_addr;
    fm_weight_t         weight_data;
    fm_acc_t            result;
    logic               result_valid;
    fm_weight_t         weight_model [`FM_TAPS];
    logic [GROUP_W-1:0] group_bits;  // The whole group, first beat at the top.
    fm_acc_t            exp_q [$];
    int                 chk_err_cnt;
    int                 test_err_cnt;
    int                 rx_cnt;
    int                 err_mark;
    int                 rx_mark;
    int                 test_cnt;
    int                 test_fail_cnt;
    logic               timed_out;

    tb_clk_gen u_clk_gen (
        .reset_req (reset_req),
        .sys_clk   (sys_clk),
        .calc_clk  (calc_clk),
        .rstn      (rstn)
    );

    fm_in_path DUT (
        .sys_clk      (sys_clk),
        .calc_clk     (calc_clk),
        .rstn         (rstn),
        .beat         (beat),
        .beat_valid   (beat_valid),
        .weight_we    (weight_we),
        .weight_addr  (weight_addr),
        .weight_data  (weight_data),
        .result       (result),
        .result_valid (result_valid)
    );

    function automatic fm_acc_t window_dot(input fm_half_t win);
        longint    sum;
        fm_pixel_t pix;
        sum = 0;
        for (int i = 0; i < `FM_TAPS; i++) begin
            pix = 16'(win >> ((`FM_TAPS - 1 - i) * `FM_PIXEL_W));
            sum += longint'(pix) * longint'(weight_model[i]);
        end
        return `FM_ACC_W'(sum);
    endfunction

    // Mode 0 is random, mode 1 mixes in the signed limits, mode 2 is all minimum.
    function automatic fm_beat_t rand_beat(input int mode);
        fm_beat_t    b;
        logic [15:0] pix;
        for (int f = 0; f < `FM_BEAT_W / `FM_PIXEL_W; f++) begin
            pix = (mode == 2) ? 16'h8000 : 16'($urandom());
            if (mode == 1 && f % 3 != 2) begin
                pix = (f % 3 == 0) ? 16'h8000 : 16'h7fff;
            end
            b[f*`FM_PIXEL_W +: `FM_PIXEL_W] = pix;
        end
        return b;
    endfunction

    task automatic next_cycle();
        @(posedge sys_clk);
        #0.5;
    endtask

    task automatic idle_cycle();
        next_cycle();
        beat_valid = 1'b0;
        weight_we  = 1'b0;
    endtask

    task automatic write_weight(input int addr, input fm_weight_t data);
        next_cycle();
        beat_valid  = 1'b0;
        weight_we   = 1'b1;
        weight_addr = 4'(addr);
        weight_data = data;
        if (addr < `FM_TAPS) begin
            weight_model[addr] = data;
        end
    endtask

    task automatic load_weights(input int mode, input int count);
        fm_weight_t w;
        for (int i = 0; i < count; i++) begin
            w = (mode == 2) ? 16'sh8000 : 16'($urandom());
            if (mode == 1 && i % 3 != 2) begin
                w = (i % 3 == 0) ? 16'sh8000 : 16'sh7fff;
            end
            write_weight(i, w);
        end
    endtask

    // Beat k completes word k-1, so both of its windows are known right away.
    task automatic send_beat(input int k, input fm_beat_t data);
        fm_word_t word;
        next_cycle();
        weight_we  = 1'b0;
        beat_valid = 1'b1;
        beat       = data;
        group_bits[GROUP_W-1-k*`FM_BEAT_W -: `FM_BEAT_W] = data;
        if (k > 0) begin
            word = group_bits[GROUP_W-1-(k-1)*`FM_WORD_W -: `FM_WORD_W];
            exp_q.push_back(window_dot(word[`FM_WORD_W-1:`FM_HALF_W]));
            exp_q.push_back(window_dot(word[`FM_HALF_W-1:0]));
        end
    endtask

    task automatic send_group(input int gap_max, input int mode);
        int gaps;
        for (int k = 0; k < `FM_BEATS_PER_GROUP; k++) begin
            gaps = (k > 0) ? int'($urandom_range(gap_max, 0)) : 0;
            repeat (gaps) begin
                idle_cycle();
            end
            send_beat(k, rand_beat(mode));
        end
    endtask

    task automatic drain_results();
        int cycles;
        idle_cycle();
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(negedge calc_clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout waiting for results");
            timed_out = 1'b1;
            test_err_cnt++;
        end
        repeat (8) begin
            @(negedge calc_clk);  // Stray results show up here as unexpected.
        end
    endtask

    task automatic start_test();
        err_mark = test_err_cnt + chk_err_cnt;
        rx_mark  = rx_cnt;
    endtask

    task automatic finish_test(input string name, input int exp_rx);
        int errs;
        assert (rx_cnt - rx_mark == exp_rx) else begin
            $display("[ERROR] result_count exp 0x%0h got 0x%0h", exp_rx, rx_cnt - rx_mark);
            test_err_cnt++;
        end
        errs = test_err_cnt + chk_err_cnt - err_mark;
        test_cnt++;
        if (errs == 0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, errs);
            test_fail_cnt++;
        end
    endtask

    // Outputs change on the rising calc_clk edge and are read on the falling one.
    always @(negedge calc_clk) begin : check_result
        fm_acc_t exp_val;
        if (result_valid) begin
            rx_cnt++;
            assert (exp_q.size() != 0) else begin
                $display("result_valid went high with no result expected");
                chk_err_cnt++;
            end
            if (exp_q.size() != 0) begin
                exp_val = exp_q.pop_front();
                assert (result == exp_val) else begin
                    $display("[ERROR] result exp 0x%09h got 0x%09h", exp_val, result);
                    chk_err_cnt++;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h1472_fb14));
        reset_req     = 1'b0;
        beat          = '0;
        beat_valid    = 1'b0;
        weight_we     = 1'b0;
        weight_addr   = '0;
        weight_data   = '0;
        group_bits    = '0;
        chk_err_cnt   = 0;
        test_err_cnt  = 0;
        rx_cnt        = 0;
        test_cnt      = 0;
        test_fail_cnt = 0;
        timed_out     = 1'b0;
        for (int i = 0; i < `FM_TAPS; i++) begin
            weight_model[i] = '0;
        end
        repeat (10) @(posedge sys_clk);

        start_test();
        load_weights(0, `FM_TAPS);
        send_group(0, 0);
        drain_results();
        finish_test("test 1 single group", 16);

        if (!timed_out) begin
            start_test();
            repeat (8) begin
                send_group(0, 0);
            end
            drain_results();
            finish_test("test 2 continuous stream", 128);
        end

        if (!timed_out) begin
            start_test();
            load_weights(0, `FM_TAPS);
            repeat (4) begin
                send_group(3, 0);
            end
            drain_results();
            finish_test("test 3 gapped input", 64);
        end

        if (!timed_out) begin
            start_test();
            load_weights(2, `FM_TAPS);
            send_group(0, 2);  // Largest positive sum the MAC can produce.
            drain_results();
            load_weights(1, `FM_TAPS);
            for (int a = `FM_TAPS; a < 16; a++) begin
                write_weight(a, 16'($urandom()));
            end
            send_group(0, 1);
            drain_results();
            finish_test("test 4 weight reload and extremes", 32);
        end

        if (!timed_out) begin
            start_test();
            load_weights(0, `FM_TAPS);
            for (int k = 0; k < 4; k++) begin
                send_beat(k, rand_beat(0));
            end
            next_cycle();
            beat_valid = 1'b0;
            reset_req  = 1'b1;
            exp_q.delete();
            for (int i = 0; i < `FM_TAPS; i++) begin
                weight_model[i] = '0;
            end
            repeat (4) begin
                next_cycle();
            end
            reset_req = 1'b0;
            rx_mark   = rx_cnt;
            load_weights(0, 5);  // Taps 5 to 8 keep their reset value of zero.
            send_group(0, 0);
            drain_results();
            finish_test("test 5 reset mid-group", 16);
        end

        $display("tests run %0d, passed %0d, failed %0d",
                 test_cnt, test_cnt - test_fail_cnt, test_fail_cnt);
        if (test_fail_cnt == 0 && !timed_out && test_err_cnt + chk_err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: fm_in_path.f
+incdir+.
logic/fm_pkg.sv
logic/fm_width_converter.sv
logic/fm_window_mac.sv
logic/fm_in_path.sv
verif/tb_clk_gen.sv
verif/fm_in_path_assert.sv
verif/tb_fm_in_path.sv

// File: run_sim.sh
#!/bin/sh

LOG=sim.log
BUILD_DIR=obj_dir

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f fm_in_path.f --top-module tb_fm_in_path \
    --Mdir "$BUILD_DIR" -o tb_fm_in_path
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_fm_in_path" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
    echo "no pass message found in $LOG"
    exit 1
fi
exit 0
